// ==== common/tiny_cpu_pkg.sv ====
`default_nettype none

package tiny_cpu_pkg;

	typedef logic [15:0] word_t;
	typedef logic [7:0]  byte_t;
	// opcode in 7:0, operand bytes above it
	typedef logic [23:0] inst_t;
	typedef logic [1:0]  reg_sel_t;
	typedef logic [1:0]  byte_en_t;
	// bit 0 c, bit 1 z, bit 2 n
	typedef logic [2:0]  flags_t;

	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;

	localparam int NUM_REGS = 3;
	localparam reg_sel_t REG_X = 2'd0;
	localparam reg_sel_t REG_Y = 2'd1;
	localparam reg_sel_t REG_Z = 2'd2;

	localparam byte_en_t BE_NONE = 2'b00;
	localparam byte_en_t BE_LOW  = 2'b01;
	localparam byte_en_t BE_WORD = 2'b11;

	localparam flags_t FLAGS_NONE = 3'b000;
	localparam flags_t FLAGS_ZN   = 3'b110;
	localparam flags_t FLAGS_ALL  = 3'b111;

	localparam word_t RESET_PC = 16'h0000;

	localparam word_t LEN_SHORT = 16'd1;
	localparam word_t LEN_IMM8  = 16'd2;
	localparam word_t LEN_IMM16 = 16'd3;

	typedef enum logic [7:0] {
		OP_NOP         = 8'h00,
		OP_LD_XL_IMMD  = 8'h10,
		OP_LDW_Y_IMMD  = 8'h11,
		OP_ADD_XL_IMMD = 8'h20,
		OP_SUB_XL_IMMD = 8'h21,
		OP_AND_XL_IMMD = 8'h22,
		OP_OR_XL_IMMD  = 8'h23,
		OP_XOR_XL_IMMD = 8'h24,
		OP_ADD_XL_ZL   = 8'h30,
		OP_INC_XL      = 8'h31,
		OP_DEC_XL      = 8'h32,
		OP_ADDW_Y_X    = 8'h33,
		OP_LDW_Z_Y     = 8'h34,
		OP_LD_XL_DIR   = 8'h40,
		OP_LD_DIR_XL   = 8'h41,
		OP_LDW_Y_DIR   = 8'h42,
		OP_LDW_DIR_Y   = 8'h43,
		OP_JP_IMMD     = 8'h50,
		OP_JR_D        = 8'h51,
		OP_JRZ_D       = 8'h52,
		OP_JRNZ_D      = 8'h53,
		OP_JRC_D       = 8'h54,
		OP_TRAP        = 8'hff
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_PASS8,
		ALU_PASSW,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_DEC,
		ALU_ADDW
	} alu_op_t;

	function automatic word_t inst_len(input opcode_t op);
		case (op)
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD,
			OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D:
				return LEN_IMM8;
			OP_LDW_Y_IMMD, OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_DIR, OP_LDW_DIR_Y,
			OP_JP_IMMD:
				return LEN_IMM16;
			default:
				return LEN_SHORT;
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== logic/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regfile
	import tiny_cpu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  reg_sel_t wr_sel,
	input  byte_en_t wr_en,
	input  word_t    wr_data,
	output word_t    x,
	output word_t    y,
	output word_t    z,
	output word_t    next_x,
	output word_t    next_y,
	output word_t    next_z
);
	word_t regs [NUM_REGS];
	word_t nxt [NUM_REGS];

	// value after this cycle's write in each byte lane
	always_comb
	begin
		for (int i = 0; i < NUM_REGS; i++)
		begin
			nxt[i] = regs[i];
			if (wr_sel == reg_sel_t'(i))
			begin
				if (wr_en[0])
					nxt[i][7:0] = wr_data[7:0];
				if (wr_en[1])
					nxt[i][15:8] = wr_data[15:8];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_REGS; i++)
		begin
			if (reset)
				regs[i] <= '0;
			else
				regs[i] <= nxt[i];
		end
	end

	assign x = regs[REG_X];
	assign y = regs[REG_Y];
	assign z = regs[REG_Z];
	assign next_x = nxt[REG_X];
	assign next_y = nxt[REG_Y];
	assign next_z = nxt[REG_Z];

	// decoder must never select the unused fourth index
	a_wr_sel_valid: assert property (@(posedge clk) disable iff (reset)
		wr_en != BE_NONE |-> wr_sel < reg_sel_t'(NUM_REGS))
	else
		$error("regfile: write to nonexistent register %0d", wr_sel);

endmodule

`default_nettype wire

// ==== alu/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import tiny_cpu_pkg::*;
(
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output flags_t  flags_out
);
	logic [8:0]  sum8;
	logic [16:0] sum16;
	logic        wide;

	always_comb
	begin
		sum8 = '0;
		sum16 = '0;
		wide = 1'b0;

		case (op)
			ALU_ADD: sum8 = {1'b0, a[7:0]} + {1'b0, b[7:0]};
			// bit 8 becomes the borrow
			ALU_SUB: sum8 = {1'b0, a[7:0]} - {1'b0, b[7:0]};
			ALU_AND: sum8 = {1'b0, a[7:0] & b[7:0]};
			ALU_OR:  sum8 = {1'b0, a[7:0] | b[7:0]};
			ALU_XOR: sum8 = {1'b0, a[7:0] ^ b[7:0]};
			ALU_INC: sum8 = {1'b0, a[7:0]} + 9'd1;
			ALU_DEC: sum8 = {1'b0, a[7:0]} - 9'd1;
			ALU_ADDW:
			begin
				sum16 = {1'b0, a} + {1'b0, b};
				wide = 1'b1;
			end
			ALU_PASSW:
			begin
				sum16 = {1'b0, a};
				wide = 1'b1;
			end
			default: sum8 = {1'b0, a[7:0]};
		endcase

		if (wide)
		begin
			result = sum16[15:0];
			flags_out[FLAG_C] = sum16[16];
			flags_out[FLAG_Z] = (sum16[15:0] == 16'h0000);
			flags_out[FLAG_N] = sum16[15];
		end
		else
		begin
			// byte ops leave the high byte clear
			result = {8'h00, sum8[7:0]};
			flags_out[FLAG_C] = sum8[8];
			flags_out[FLAG_Z] = (sum8[7:0] == 8'h00);
			flags_out[FLAG_N] = sum8[7];
		end
	end

endmodule

`default_nettype wire

// ==== core/fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch
	import tiny_cpu_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  inst_t  iread_data,
	input  flags_t next_flags,
	output word_t  iread_addr,
	output word_t  dread_addr,
	output inst_t  inst
);
	word_t   pc;
	word_t   next_pc;
	opcode_t fetch_op;
	word_t   disp;
	logic    jr_taken;

	// iread_data holds the word at pc, one ahead of execute
	assign fetch_op = opcode_t'(iread_data[7:0]);
	assign disp = {{8{iread_data[15]}}, iread_data[15:8]};

	// flags as they will be after the instruction now in execute
	always_comb
	begin
		case (fetch_op)
			OP_JR_D:   jr_taken = 1'b1;
			OP_JRZ_D:  jr_taken = next_flags[FLAG_Z];
			OP_JRNZ_D: jr_taken = !next_flags[FLAG_Z];
			OP_JRC_D:  jr_taken = next_flags[FLAG_C];
			default:   jr_taken = 1'b0;
		endcase
	end

	always_comb
	begin
		if (reset)
			next_pc = RESET_PC;
		else if (fetch_op == OP_JP_IMMD)
			next_pc = iread_data[23:8];
		else if (jr_taken)
			next_pc = pc + disp;
		else
			next_pc = pc + inst_len(fetch_op);
	end

	assign iread_addr = next_pc;

	// direct loads are the only reads, data arrives for execute
	assign dread_addr = iread_data[23:8];

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
			inst <= {16'h0000, OP_NOP};
		else
			inst <= iread_data;
	end

endmodule

`default_nettype wire

// ==== core/decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module decoder
	import tiny_cpu_pkg::*;
(
	input  inst_t    inst,
	input  word_t    x,
	input  word_t    y,
	input  word_t    z,
	input  word_t    dread_data,
	output alu_op_t  alu_op,
	output word_t    alu_a,
	output word_t    alu_b,
	output flags_t   flags_we,
	output reg_sel_t reg_wr_sel,
	output byte_en_t reg_wr_en,
	output word_t    mem_wr_addr,
	output byte_en_t mem_wr_en,
	output logic     trap
);
	opcode_t op;
	byte_t   imm8;
	word_t   imm16;

	assign op = opcode_t'(inst[7:0]);
	assign imm8 = inst[15:8];
	assign imm16 = inst[23:8];

	// stores only use the direct address field
	assign mem_wr_addr = imm16;
	assign trap = (op == OP_TRAP);

	always_comb
	begin
		alu_op = ALU_PASS8;
		alu_a = x;
		alu_b = {8'h00, imm8};
		flags_we = FLAGS_NONE;
		reg_wr_sel = REG_X;
		reg_wr_en = BE_NONE;
		mem_wr_en = BE_NONE;

		// operation and operands
		case (op)
			OP_ADD_XL_IMMD: alu_op = ALU_ADD;
			OP_SUB_XL_IMMD: alu_op = ALU_SUB;
			OP_AND_XL_IMMD: alu_op = ALU_AND;
			OP_OR_XL_IMMD:  alu_op = ALU_OR;
			OP_XOR_XL_IMMD: alu_op = ALU_XOR;
			OP_INC_XL:      alu_op = ALU_INC;
			OP_DEC_XL:      alu_op = ALU_DEC;
			OP_ADD_XL_ZL:
			begin
				alu_op = ALU_ADD;
				alu_b = z;
			end
			OP_ADDW_Y_X:
			begin
				alu_op = ALU_ADDW;
				alu_a = y;
				alu_b = x;
			end
			OP_LD_XL_IMMD: alu_a = {8'h00, imm8};
			OP_LD_XL_DIR:  alu_a = dread_data;
			OP_LDW_Y_IMMD:
			begin
				alu_op = ALU_PASSW;
				alu_a = imm16;
			end
			OP_LDW_Y_DIR:
			begin
				alu_op = ALU_PASSW;
				alu_a = dread_data;
			end
			OP_LDW_Z_Y, OP_LDW_DIR_Y:
			begin
				alu_op = ALU_PASSW;
				alu_a = y;
			end
			default: alu_op = ALU_PASS8;
		endcase

		// destinations and flag updates
		case (op)
			OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD, OP_OR_XL_IMMD,
			OP_XOR_XL_IMMD, OP_ADD_XL_ZL, OP_INC_XL, OP_DEC_XL:
			begin
				reg_wr_en = BE_LOW;
				flags_we = FLAGS_ALL;
			end
			OP_ADDW_Y_X:
			begin
				reg_wr_sel = REG_Y;
				reg_wr_en = BE_WORD;
				flags_we = FLAGS_ALL;
			end
			OP_LD_XL_IMMD, OP_LD_XL_DIR:
			begin
				reg_wr_en = BE_LOW;
				flags_we = FLAGS_ZN;
			end
			OP_LDW_Y_IMMD, OP_LDW_Y_DIR:
			begin
				reg_wr_sel = REG_Y;
				reg_wr_en = BE_WORD;
				flags_we = FLAGS_ZN;
			end
			OP_LDW_Z_Y:
			begin
				reg_wr_sel = REG_Z;
				reg_wr_en = BE_WORD;
				flags_we = FLAGS_ZN;
			end
			OP_LD_DIR_XL: mem_wr_en = BE_LOW;
			OP_LDW_DIR_Y: mem_wr_en = BE_WORD;
			default:      reg_wr_en = BE_NONE;
		endcase
	end

endmodule

`default_nettype wire

// ==== core/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top
	import tiny_cpu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	output word_t    iread_addr,
	input  inst_t    iread_data,
	output word_t    dread_addr,
	input  word_t    dread_data,
	output word_t    dwrite_addr,
	output word_t    dwrite_data,
	output byte_en_t dwrite_en,
	output logic     trap
);
	inst_t    inst;
	flags_t   flags;
	flags_t   next_flags;
	flags_t   alu_flags;
	flags_t   flags_we;
	alu_op_t  alu_op;
	word_t    alu_a;
	word_t    alu_b;
	word_t    alu_result;
	reg_sel_t reg_wr_sel;
	byte_en_t reg_wr_en;
	word_t    x;
	word_t    y;
	word_t    z;

	fetch fetch0 (
		.clk        (clk),
		.reset      (reset),
		.iread_data (iread_data),
		.next_flags (next_flags),
		.iread_addr (iread_addr),
		.dread_addr (dread_addr),
		.inst       (inst)
	);

	decoder decoder0 (
		.inst        (inst),
		.x           (x),
		.y           (y),
		.z           (z),
		.dread_data  (dread_data),
		.alu_op      (alu_op),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.flags_we    (flags_we),
		.reg_wr_sel  (reg_wr_sel),
		.reg_wr_en   (reg_wr_en),
		.mem_wr_addr (dwrite_addr),
		.mem_wr_en   (dwrite_en),
		.trap        (trap)
	);

	alu alu0 (
		.op        (alu_op),
		.a         (alu_a),
		.b         (alu_b),
		.result    (alu_result),
		.flags_out (alu_flags)
	);

	// write-through values stay open, no opcode here branches on a register
	regfile regfile0 (
		.clk     (clk),
		.reset   (reset),
		.wr_sel  (reg_wr_sel),
		.wr_en   (reg_wr_en),
		.wr_data (alu_result),
		.x       (x),
		.y       (y),
		.z       (z),
		.next_x  (),
		.next_y  (),
		.next_z  ()
	);

	// stores go through the alu pass path
	assign dwrite_data = alu_result;

	// unmasked flags keep their old value
	assign next_flags = (flags & ~flags_we) | (alu_flags & flags_we);

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	// fetch has put a NOP in execute after the first reset edge
	a_no_write_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> dwrite_en == BE_NONE)
	else
		$error("cpu_top: data write during reset");

endmodule

`default_nettype wire

// ==== dv/cpu_ref.svh ====
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

// instruction-set model state
word_t  m_pc;
word_t  m_x;
word_t  m_y;
word_t  m_z;
flags_t m_flags;
byte_t  m_mem [0:65535];
byte_t  prog [$];

function automatic void ref_reset();
	m_pc = RESET_PC;
	m_x = '0;
	m_y = '0;
	m_z = '0;
	m_flags = '0;
endfunction

// c from bit 8, z and n from the low byte
function automatic void put_x8(input logic [8:0] r, input flags_t mask);
	flags_t f;
	f = {r[7], r[7:0] == 8'h00, r[8]};
	m_x[7:0] = r[7:0];
	m_flags = (m_flags & ~mask) | (f & mask);
endfunction

function automatic void set_flags16(input logic [16:0] r, input flags_t mask);
	flags_t f;
	f = {r[15], r[15:0] == 16'h0000, r[16]};
	m_flags = (m_flags & ~mask) | (f & mask);
endfunction

// one instruction; returns 1 when it stores
function automatic bit ref_step(output word_t s_addr, output byte_en_t s_en,
		output word_t s_data, output bit halted);
	opcode_t     op;
	byte_t       b1;
	word_t       w;
	word_t       nxt;
	logic [16:0] r17;
	bit          st;
	op = opcode_t'(imem[m_pc]);
	b1 = imem[m_pc + 16'd1];
	w = {imem[m_pc + 16'd2], b1};
	nxt = m_pc + inst_len(op);
	st = 1'b0;
	halted = 1'b0;
	s_addr = w;
	s_en = BE_NONE;
	s_data = '0;
	case (op)
		OP_LD_XL_IMMD:  put_x8({1'b0, b1}, FLAGS_ZN);
		OP_ADD_XL_IMMD: put_x8(9'(m_x[7:0]) + 9'(b1), FLAGS_ALL);
		OP_SUB_XL_IMMD: put_x8(9'(m_x[7:0]) - 9'(b1), FLAGS_ALL);
		OP_AND_XL_IMMD: put_x8({1'b0, m_x[7:0] & b1}, FLAGS_ALL);
		OP_OR_XL_IMMD:  put_x8({1'b0, m_x[7:0] | b1}, FLAGS_ALL);
		OP_XOR_XL_IMMD: put_x8({1'b0, m_x[7:0] ^ b1}, FLAGS_ALL);
		OP_ADD_XL_ZL:   put_x8(9'(m_x[7:0]) + 9'(m_z[7:0]), FLAGS_ALL);
		OP_INC_XL:      put_x8(9'(m_x[7:0]) + 9'd1, FLAGS_ALL);
		OP_DEC_XL:      put_x8(9'(m_x[7:0]) - 9'd1, FLAGS_ALL);
		OP_LD_XL_DIR:   put_x8({1'b0, m_mem[w]}, FLAGS_ZN);
		OP_ADDW_Y_X:
		begin
			r17 = 17'(m_y) + 17'(m_x);
			m_y = r17[15:0];
			set_flags16(r17, FLAGS_ALL);
		end
		OP_LDW_Y_IMMD:
		begin
			m_y = w;
			set_flags16({1'b0, m_y}, FLAGS_ZN);
		end
		OP_LDW_Y_DIR:
		begin
			m_y = {m_mem[w + 16'd1], m_mem[w]};
			set_flags16({1'b0, m_y}, FLAGS_ZN);
		end
		OP_LDW_Z_Y:
		begin
			m_z = m_y;
			set_flags16({1'b0, m_z}, FLAGS_ZN);
		end
		OP_LD_DIR_XL:
		begin
			m_mem[w] = m_x[7:0];
			st = 1'b1;
			s_en = BE_LOW;
			s_data = {8'h00, m_x[7:0]};
		end
		OP_LDW_DIR_Y:
		begin
			m_mem[w] = m_y[7:0];
			m_mem[w + 16'd1] = m_y[15:8];
			st = 1'b1;
			s_en = BE_WORD;
			s_data = m_y;
		end
		OP_JP_IMMD: nxt = w;
		OP_JR_D:    nxt = m_pc + {{8{b1[7]}}, b1};
		OP_JRZ_D:   nxt = m_flags[FLAG_Z] ? m_pc + {{8{b1[7]}}, b1} : nxt;
		OP_JRNZ_D:  nxt = !m_flags[FLAG_Z] ? m_pc + {{8{b1[7]}}, b1} : nxt;
		OP_JRC_D:   nxt = m_flags[FLAG_C] ? m_pc + {{8{b1[7]}}, b1} : nxt;
		OP_TRAP:
		begin
			halted = 1'b1;
			nxt = m_pc;
		end
		default: nxt = nxt;
	endcase
	m_pc = nxt;
	return st;
endfunction

// program builder
function automatic void put1(input opcode_t op);
	prog.push_back(op);
endfunction

function automatic void put2(input opcode_t op, input byte_t b);
	prog.push_back(op);
	prog.push_back(b);
endfunction

function automatic void put3(input opcode_t op, input word_t w);
	prog.push_back(op);
	prog.push_back(w[7:0]);
	prog.push_back(w[15:8]);
endfunction

`endif

// ==== dv/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
	import tiny_cpu_pkg::*;
;
	logic     clk;
	logic     reset;
	word_t    iread_addr;
	inst_t    iread_data;
	word_t    dread_addr;
	word_t    dread_data;
	word_t    dwrite_addr;
	word_t    dwrite_data;
	byte_en_t dwrite_en;
	logic     trap;

	byte_t    imem [0:65535];
	byte_t    dmem [0:65535];
	word_t    iaddr_q;
	word_t    daddr_q;
	word_t    prev_iaddr;
	word_t    exp_addr [$];
	byte_en_t exp_en [$];
	word_t    exp_data [$];
	word_t    ref_trap_pc;
	bit       trap_seen;
	int       errors;
	int       tests_failed;
	int       tests_run;
	int       cycles;
	int       cycle_limit;

	`include "cpu_ref.svh"

	cpu_top dut0 (
		.clk         (clk),
		.reset       (reset),
		.iread_addr  (iread_addr),
		.iread_data  (iread_data),
		.dread_addr  (dread_addr),
		.dread_data  (dread_data),
		.dwrite_addr (dwrite_addr),
		.dwrite_data (dwrite_data),
		.dwrite_en   (dwrite_en),
		.trap        (trap)
	);

	always #5 clk = ~clk;

	// memories latch the address on the rising edge and drive data on the falling edge
	always @(posedge clk)
	begin
		iaddr_q <= iread_addr;
		daddr_q <= dread_addr;
		if (dwrite_en[0])
			dmem[dwrite_addr] = dwrite_data[7:0];
		if (dwrite_en[1])
			dmem[dwrite_addr + 16'd1] = dwrite_data[15:8];
	end

	always @(negedge clk)
	begin
		iread_data = {imem[iaddr_q + 16'd2], imem[iaddr_q + 16'd1], imem[iaddr_q]};
		dread_data = {dmem[daddr_q + 16'd1], dmem[daddr_q]};
	end

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s is %04h, expected %04h", $time, what, got, exp);
		end
	endtask

	task automatic check_en(input string what, input byte_en_t got, input byte_en_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_trap_pc(input word_t got, input word_t exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: fetch address before trap is %04h, expected %04h",
				$time, got, exp);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			errors++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// stores are compared in program order
	always @(posedge clk)
	begin
		prev_iaddr <= iread_addr;
		if (!reset && !trap_seen)
		begin
			if (dwrite_en != BE_NONE)
			begin
				if (exp_addr.size() == 0)
				begin
					errors++;
					$display("ERROR %0t: unexpected store to %04h", $time, dwrite_addr);
				end
				else
				begin
					check_word("store address", dwrite_addr, exp_addr.pop_front());
					check_en("store enables", dwrite_en, exp_en.pop_front());
					check_word("store data", dwrite_data, exp_data.pop_front());
				end
			end
			if (trap)
			begin
				trap_seen = 1'b1;
				check_trap_pc(prev_iaddr, ref_trap_pc + LEN_SHORT);
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout: the DUT did not reach a trap within %0d cycles", cycle_limit);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic run_program(input string name);
		word_t    a;
		byte_en_t e;
		word_t    d;
		bit       halted;
		int       n;
		int       e0;
		int       n_st;
		string    verdict;
		e0 = errors;
		@(negedge clk);
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
		begin
			imem[i] = 8'hff;
			dmem[i] = byte_t'(i) ^ byte_t'(i >> 8) ^ 8'h5c;
			m_mem[i] = dmem[i];
		end
		foreach (prog[i])
			imem[i] = prog[i];
		exp_addr.delete();
		exp_en.delete();
		exp_data.delete();
		ref_reset();
		n = 0;
		halted = 1'b0;
		while (!halted && n < 2000)
		begin
			if (ref_step(a, e, d, halted))
			begin
				exp_addr.push_back(a);
				exp_en.push_back(e);
				exp_data.push_back(d);
			end
			n++;
		end
		if (!halted)
		begin
			errors++;
			$display("model of program %s never reached a trap", name);
		end
		ref_trap_pc = m_pc;
		n_st = exp_addr.size();
		cycle_limit += 2 * n + 4;
		trap_seen = 1'b0;
		repeat (3) @(posedge clk);
		check_word("iread_addr in reset", iread_addr, RESET_PC);
		check_en("dwrite_en in reset", dwrite_en, BE_NONE);
		check_bit("trap in reset", trap, 1'b0);
		@(negedge clk);
		reset = 1'b0;
		#1;
		check_en("dwrite_en after reset", dwrite_en, BE_NONE);
		check_bit("trap after reset", trap, 1'b0);
		do
			@(posedge clk);
		while (!trap_seen);
		if (exp_addr.size() != 0)
		begin
			errors++;
			$display("%0d expected stores never happened", exp_addr.size());
		end
		tests_run++;
		if (errors != e0)
			tests_failed++;
		if (errors == e0)
			verdict = "ok";
		else
			verdict = "FAILED";
		$display("test %s: %s, %0d instructions, %0d stores", name, verdict, n, n_st);
		prog.delete();
	endtask

	// a taken branch skips the marker store after it
	task automatic branch(input opcode_t op, inout word_t mark);
		put2(op, 8'd5);
		put3(OP_LD_DIR_XL, mark);
		mark++;
	endtask

	initial
	begin
		word_t mark;
		void'($urandom(32'ha7fd));
		clk = 1'b0;
		reset = 1'b1;
		iread_data = '0;
		dread_data = '0;
		errors = 0;
		tests_failed = 0;
		tests_run = 0;
		cycles = 0;
		cycle_limit = 100;
		trap_seen = 1'b0;
		ref_trap_pc = '0;

		put2(OP_LD_XL_IMMD, 8'h5a);
		put2(OP_ADD_XL_IMMD, 8'hc3);
		put3(OP_LD_DIR_XL, 16'h0200);
		put2(OP_SUB_XL_IMMD, 8'h7f);
		put3(OP_LD_DIR_XL, 16'h0201);
		put2(OP_AND_XL_IMMD, 8'hf0);
		put3(OP_LD_DIR_XL, 16'h0202);
		put2(OP_OR_XL_IMMD, 8'h0f);
		put3(OP_LD_DIR_XL, 16'h0203);
		put2(OP_XOR_XL_IMMD, 8'haa);
		put3(OP_LD_DIR_XL, 16'h0204);
		put1(OP_INC_XL);
		put3(OP_LD_DIR_XL, 16'h0205);
		put1(OP_DEC_XL);
		put3(OP_LD_DIR_XL, 16'h0206);
		put3(OP_LDW_Y_IMMD, 16'h1234);
		put1(OP_LDW_Z_Y);
		put1(OP_ADD_XL_ZL);
		put3(OP_LD_DIR_XL, 16'h0207);
		put1(OP_ADDW_Y_X);
		put3(OP_LDW_DIR_Y, 16'h0210);
		put3(OP_LDW_Y_IMMD, 16'hfff0);
		put1(OP_ADDW_Y_X);
		put3(OP_LDW_DIR_Y, 16'h0212);
		put1(OP_TRAP);
		run_program("arith");

		put3(OP_LD_XL_DIR, 16'h0300);
		put1(OP_INC_XL);
		put3(OP_LD_DIR_XL, 16'h0310);
		put2(OP_LD_XL_IMMD, 8'h00);
		put3(OP_LD_XL_DIR, 16'h0310);
		put2(OP_ADD_XL_IMMD, 8'h03);
		put3(OP_LD_DIR_XL, 16'h0311);
		put3(OP_LDW_Y_DIR, 16'h0320);
		put1(OP_ADDW_Y_X);
		put3(OP_LDW_DIR_Y, 16'h0330);
		put3(OP_LDW_Y_IMMD, 16'h0000);
		put3(OP_LDW_Y_DIR, 16'h0330);
		put3(OP_LDW_DIR_Y, 16'h0334);
		put1(OP_TRAP);
		run_program("memory");

		mark = 16'h0100;
		put2(OP_LD_XL_IMMD, 8'h00);
		branch(OP_JRZ_D, mark);
		put2(OP_LD_XL_IMMD, 8'h11);
		branch(OP_JRZ_D, mark);
		branch(OP_JRNZ_D, mark);
		put2(OP_LD_XL_IMMD, 8'hff);
		put2(OP_ADD_XL_IMMD, 8'h01);
		branch(OP_JRC_D, mark);
		branch(OP_JRNZ_D, mark);
		put2(OP_SUB_XL_IMMD, 8'h00);
		branch(OP_JRC_D, mark);
		branch(OP_JR_D, mark);
		put3(OP_JP_IMMD, word_t'(prog.size() + 6));
		put3(OP_LD_DIR_XL, 16'h01f0);
		put3(OP_LD_DIR_XL, 16'h01f1);
		put1(OP_TRAP);
		run_program("branch");

		for (int t = 0; t < 20; t++)
		begin
			repeat ($urandom_range(5, 15))
			begin
				case ($urandom_range(0, 11))
					0: put2(OP_ADD_XL_IMMD, byte_t'($urandom));
					1: put2(OP_SUB_XL_IMMD, byte_t'($urandom));
					2: put2(OP_AND_XL_IMMD, byte_t'($urandom));
					3: put2(OP_OR_XL_IMMD, byte_t'($urandom));
					4: put2(OP_XOR_XL_IMMD, byte_t'($urandom));
					5: put1(OP_INC_XL);
					6: put1(OP_DEC_XL);
					7: put1(OP_ADD_XL_ZL);
					8: put1(OP_ADDW_Y_X);
					9: put2(OP_LD_XL_IMMD, byte_t'($urandom));
					10: put3(OP_LDW_Y_IMMD, word_t'($urandom));
					default: put1(OP_LDW_Z_Y);
				endcase
				if ($urandom_range(0, 1))
					put3(OP_LD_DIR_XL, 16'h0400 + word_t'($urandom_range(0, 255)));
				else
					put3(OP_LDW_DIR_Y, 16'h0400 + word_t'($urandom_range(0, 255)));
			end
			put1(OP_TRAP);
			run_program($sformatf("random%0d", t));
		end

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tiny_cpu.f ====
+incdir+dv
common/tiny_cpu_pkg.sv
logic/regfile.sv
alu/alu.sv
core/fetch.sv
core/decoder.sv
core/cpu_top.sv
dv/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= tiny_cpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
